// ==== design/game_pkg.sv ====
// ********************
// match states, score width and winning score
// ********************

package game_pkg;

    // match progress as seen from this board
    typedef enum logic [1:0] {
        GS_IDLE    = 2'd0,  // waiting for the first start
        GS_SHOOTER = 2'd1,  // this board takes the shot
        GS_KEEPER  = 2'd2,  // this board keeps goal
        GS_OVER    = 2'd3   // match decided
    } game_state_e;

    // goal counter width, enough for 0..WIN_SCORE
    localparam int SCORE_W = 3;

    // first side to this many goals wins
    localparam int WIN_SCORE = 5;

endpackage

// ==== design/link_pkg.sv ====
// ********************
// score frame format and uart link constants
// ********************

package link_pkg;

    typedef enum logic {
        FRM_ROUND = 1'b0,  // match goes on
        FRM_FINAL = 1'b1   // last frame of the match
    } frame_kind_e;

    // one byte on the wire, msb first in this order
    typedef struct packed {
        frame_kind_e                     kind;        // bit 7
        logic                            result;      // bit 6, player won
        logic [game_pkg::SCORE_W-1:0]    player_pts;  // bits 5..3
        logic [game_pkg::SCORE_W-1:0]    enemy_pts;   // bits 2..0
    } score_frame_t;

    // frames held between scorer and transmitter
    localparam int FRAME_DEPTH = 4;

    // clock cycles per serial bit
    localparam int CLKS_PER_BIT = 8;

endpackage

// ==== design/score_frame_if.sv ====
// ********************
// score frame bus, scorer to buffer
// ********************

interface score_frame_if;

    logic                            push;        // one cycle per frame
    link_pkg::frame_kind_e           kind;
    logic                            result;
    logic [game_pkg::SCORE_W-1:0]    player_pts;
    logic [game_pkg::SCORE_W-1:0]    enemy_pts;

    // no acknowledge, fields valid while push is high
    modport source (
        output push,
        output kind,
        output result,
        output player_pts,
        output enemy_pts
    );

    modport sink (
        input push,
        input kind,
        input result,
        input player_pts,
        input enemy_pts
    );

endinterface

// ==== design/score_control.sv ====
// ********************
// match fsm and score counters
// one frame pushed per counted round
// ********************

module score_control (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic                            round_done_gk,
    input  logic                            is_scored_gk,
    input  logic                            round_done_sh,
    input  logic                            is_scored_sh,
    output game_pkg::game_state_e           game_state,
    output logic                            match_end,     // match decided
    output logic                            match_result,  // 1 = player won
    output logic [game_pkg::SCORE_W-1:0]    score_player,
    output logic [game_pkg::SCORE_W-1:0]    score_enemy,
    score_frame_if.source                   frame
);

    game_pkg::game_state_e           state_nxt;
    logic [game_pkg::SCORE_W-1:0]    player_nxt;
    logic [game_pkg::SCORE_W-1:0]    enemy_nxt;
    logic                            end_nxt;
    logic                            result_nxt;
    logic                            match_start;
    logic                            shot_counted;
    logic                            save_counted;
    logic                            round_counted;
    logic                            player_wins;
    logic                            enemy_wins;
    logic                            push_q;

    // a strobe only counts in its own role
    assign shot_counted  = (game_state == game_pkg::GS_SHOOTER) && round_done_sh;
    assign save_counted  = (game_state == game_pkg::GS_KEEPER) && round_done_gk;
    assign round_counted = shot_counted || save_counted;

    assign match_start = start &&
                         ((game_state == game_pkg::GS_IDLE) || (game_state == game_pkg::GS_OVER));

    // next scores, win check runs on these
    always_comb begin
        player_nxt = score_player;
        enemy_nxt  = score_enemy;
        if (match_start) begin
            player_nxt = '0;
            enemy_nxt  = '0;
        end else if (shot_counted && is_scored_sh) begin
            player_nxt = score_player + 1'b1;
        end else if (save_counted && is_scored_gk) begin
            enemy_nxt = score_enemy + 1'b1;  // enemy got past our keeper
        end
    end

    assign player_wins = round_counted && (int'(player_nxt) == game_pkg::WIN_SCORE);
    assign enemy_wins  = round_counted && (int'(enemy_nxt) == game_pkg::WIN_SCORE);

    always_comb begin
        state_nxt  = game_state;
        end_nxt    = match_end;
        result_nxt = match_result;
        case (game_state)
            game_pkg::GS_IDLE,
            game_pkg::GS_OVER: begin
                if (match_start) begin
                    state_nxt  = game_pkg::GS_SHOOTER;
                    end_nxt    = 1'b0;
                    result_nxt = 1'b0;
                end
            end
            game_pkg::GS_SHOOTER: begin
                if (shot_counted) begin
                    state_nxt = game_pkg::GS_KEEPER;
                end
            end
            game_pkg::GS_KEEPER: begin
                if (save_counted) begin
                    state_nxt = game_pkg::GS_SHOOTER;
                end
            end
            default: state_nxt = game_pkg::GS_IDLE;
        endcase

        // a win overrides the role swap
        if (player_wins || enemy_wins) begin
            state_nxt  = game_pkg::GS_OVER;
            end_nxt    = 1'b1;
            result_nxt = player_wins;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state   <= game_pkg::GS_IDLE;
            match_end    <= 1'b0;
            match_result <= 1'b0;
            score_player <= '0;
            score_enemy  <= '0;
            push_q       <= 1'b0;
        end else begin
            game_state   <= state_nxt;
            match_end    <= end_nxt;
            match_result <= result_nxt;
            score_player <= player_nxt;
            score_enemy  <= enemy_nxt;
            push_q       <= round_counted;  // no frame for a start
        end
    end

    // frame mirrors the registers updated on the same edge
    assign frame.push       = push_q;
    assign frame.kind       = match_end ? link_pkg::FRM_FINAL : link_pkg::FRM_ROUND;
    assign frame.result     = match_result;
    assign frame.player_pts = score_player;
    assign frame.enemy_pts  = score_enemy;

endmodule

// ==== design/frame_fifo.sv ====
// ********************
// score frame buffer
// drops on full, sticky overflow
// ********************

module frame_fifo (
    input  logic                    clk,
    input  logic                    rst,
    score_frame_if.sink             frame,
    input  logic                    pop,
    output link_pkg::score_frame_t  head,
    output logic                    empty,
    output logic                    overflow
);

    link_pkg::score_frame_t                              mem [link_pkg::FRAME_DEPTH];
    link_pkg::score_frame_t                              in_frame;
    logic [$clog2(link_pkg::FRAME_DEPTH)-1:0]            wr_ptr;
    logic [$clog2(link_pkg::FRAME_DEPTH)-1:0]            rd_ptr;
    logic [$clog2(link_pkg::FRAME_DEPTH+1)-1:0]          count;
    logic                                                full;
    logic                                                do_push;
    logic                                                do_pop;

    always_comb begin
        in_frame.kind       = frame.kind;
        in_frame.result     = frame.result;
        in_frame.player_pts = frame.player_pts;
        in_frame.enemy_pts  = frame.enemy_pts;
    end

    assign empty = (count == '0);
    assign full  = (int'(count) == link_pkg::FRAME_DEPTH);
    assign head  = mem[rd_ptr];

    assign do_pop  = pop && !empty;
    assign do_push = frame.push && (!full || do_pop);  // full but draining still takes it

    // storage only, no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= in_frame;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (int'(wr_ptr) == link_pkg::FRAME_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (int'(rd_ptr) == link_pkg::FRAME_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (frame.push && !do_push) begin
                overflow <= 1'b1;  // frame lost, held until reset
            end
        end
    end

endmodule

// ==== design/frame_uart_tx.sv ====
// ********************
// frame to byte, 8N1 serial out
// ********************

module frame_uart_tx (
    input  logic                    clk,
    input  logic                    rst,
    input  link_pkg::score_frame_t  head,
    input  logic                    empty,
    output logic                    pop,
    output logic                    tx,
    output logic                    busy
);

    logic                                        active;    // shifting a frame
    logic [9:0]                                  shreg;     // stop, data, start
    logic [$clog2(link_pkg::CLKS_PER_BIT)-1:0]   clk_cnt;
    logic [3:0]                                  bit_cnt;
    logic [7:0]                                  tx_byte;
    logic                                        bit_end;

    // kind, result, player, enemy from msb down
    assign tx_byte = {head.kind, head.result, head.player_pts, head.enemy_pts};

    assign pop     = !active && !empty;
    assign busy    = active || pop;
    assign tx      = shreg[0];
    assign bit_end = (int'(clk_cnt) == link_pkg::CLKS_PER_BIT - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            shreg   <= '1;  // line idles high
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (pop) begin
            active  <= 1'b1;
            shreg   <= {1'b1, tx_byte, 1'b0};
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (active) begin
            if (bit_end) begin
                clk_cnt <= '0;
                shreg   <= {1'b1, shreg[9:1]};  // lsb first, refill with idle level
                if (bit_cnt == 4'd9) begin
                    active  <= 1'b0;  // stop bit done
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/score_link_top.sv ====
// ********************
// scorer, frame buffer and uart tx
// ********************

module score_link_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic                            round_done_gk,
    input  logic                            is_scored_gk,
    input  logic                            round_done_sh,
    input  logic                            is_scored_sh,
    output game_pkg::game_state_e           game_state,
    output logic                            match_end,
    output logic                            match_result,
    output logic [game_pkg::SCORE_W-1:0]    score_player,
    output logic [game_pkg::SCORE_W-1:0]    score_enemy,
    output logic                            tx,
    output logic                            tx_busy,
    output logic                            link_overflow
);

    link_pkg::score_frame_t  fifo_head;
    logic                    fifo_empty;
    logic                    fifo_pop;

    score_frame_if frame_bus ();

    score_control u_score_control (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .round_done_gk (round_done_gk),
        .is_scored_gk  (is_scored_gk),
        .round_done_sh (round_done_sh),
        .is_scored_sh  (is_scored_sh),
        .game_state    (game_state),
        .match_end     (match_end),
        .match_result  (match_result),
        .score_player  (score_player),
        .score_enemy   (score_enemy),
        .frame         (frame_bus.source)
    );

    frame_fifo u_frame_fifo (
        .clk      (clk),
        .rst      (rst),
        .frame    (frame_bus.sink),
        .pop      (fifo_pop),
        .head     (fifo_head),
        .empty    (fifo_empty),
        .overflow (link_overflow)
    );

    frame_uart_tx u_frame_uart_tx (
        .clk   (clk),
        .rst   (rst),
        .head  (fifo_head),
        .empty (fifo_empty),
        .pop   (fifo_pop),
        .tx    (tx),
        .busy  (tx_busy)
    );

endmodule

// ==== bench/score_link_tb.sv ====
// ********************
// score_link_top testbench with stimulus, serial receiver
// reference scoring and frame comparison
// ********************

module score_link_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [game_pkg::SCORE_W-1:0]    player;
        logic [game_pkg::SCORE_W-1:0]    enemy;
        game_pkg::game_state_e           state;
        logic                            ended;
        logic                            result;
        logic [7:0]                      frame;
    } round_ref_t;

    logic                            clk = 1'b0;
    logic                            rst;
    logic                            start;
    logic                            round_done_gk;
    logic                            is_scored_gk;
    logic                            round_done_sh;
    logic                            is_scored_sh;
    game_pkg::game_state_e           game_state;
    logic                            match_end;
    logic                            match_result;
    logic [game_pkg::SCORE_W-1:0]    score_player;
    logic [game_pkg::SCORE_W-1:0]    score_enemy;
    logic                            tx;
    logic                            tx_busy;
    logic                            link_overflow;

    // model state fed from inputs only
    logic [game_pkg::SCORE_W-1:0]    m_player;
    logic [game_pkg::SCORE_W-1:0]    m_enemy;
    game_pkg::game_state_e           m_state;
    logic                            m_end;
    logic                            m_result;

    logic [7:0]  exp_q[$];
    logic [7:0]  rcv_q[$];
    int          rcv_total = 0;
    int          errors = 0;  // value mismatches
    int          fails = 0;   // timeouts, framing, missing bytes

    always #2 clk = ~clk;

    score_link_top score_link_top_i (.*);

    // expected outcome of one counted round
    function automatic round_ref_t next_score(input logic [game_pkg::SCORE_W-1:0] player,
                                              input logic [game_pkg::SCORE_W-1:0] enemy,
                                              input game_pkg::game_state_e role,
                                              input logic scored);
        round_ref_t r;
        r.player = player;
        r.enemy  = enemy;
        if (scored && role == game_pkg::GS_SHOOTER) r.player = player + 1'b1;
        if (scored && role == game_pkg::GS_KEEPER) r.enemy = enemy + 1'b1;
        r.result = (int'(r.player) == game_pkg::WIN_SCORE);
        r.ended  = r.result || (int'(r.enemy) == game_pkg::WIN_SCORE);
        if (r.ended) r.state = game_pkg::GS_OVER;
        else if (role == game_pkg::GS_SHOOTER) r.state = game_pkg::GS_KEEPER;
        else r.state = game_pkg::GS_SHOOTER;
        r.frame = {r.ended, r.result, r.player, r.enemy};  // kind, result, player, enemy
        return r;
    endfunction

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_value("score_player", 8'(score_player), 8'(m_player));
        check_value("score_enemy", 8'(score_enemy), 8'(m_enemy));
        check_value("game_state", 8'(game_state), 8'(m_state));
        check_value("match_end", 8'(match_end), 8'(m_end));
        check_value("match_result", 8'(match_result), 8'(m_result));
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        while (tx_busy !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (tx_busy !== level) begin
            fails++;
            $display("timeout: tx_busy never went to %0d", level);
        end
    endtask

    // every expected byte has been matched by the comparer
    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            fails++;
            $display("timeout: %0d expected frames never arrived", exp_q.size());
        end
    endtask

    task automatic start_match();
        start = 1'b1;
        @(negedge clk);
        start    = 1'b0;
        m_player = '0;
        m_enemy  = '0;
        m_state  = game_pkg::GS_SHOOTER;
        m_end    = 1'b0;
        m_result = 1'b0;
        check_outputs();
    endtask

    task automatic send_round(input logic scored);
        round_ref_t r;
        r = next_score(m_player, m_enemy, m_state, scored);
        if (m_state == game_pkg::GS_SHOOTER) begin
            round_done_sh = 1'b1;
            is_scored_sh  = scored;
        end else begin
            round_done_gk = 1'b1;
            is_scored_gk  = scored;
        end
        exp_q.push_back(r.frame);
        @(negedge clk);
        round_done_sh = 1'b0;
        is_scored_sh  = 1'b0;
        round_done_gk = 1'b0;
        is_scored_gk  = 1'b0;
        m_player = r.player;
        m_enemy  = r.enemy;
        m_state  = r.state;
        m_end    = r.ended;
        m_result = r.result;
        check_outputs();
    endtask

    // scored strobes that do not belong to the current role
    task automatic try_wrong_role();
        if (m_state != game_pkg::GS_SHOOTER) begin
            round_done_sh = 1'b1;
            is_scored_sh  = 1'b1;
        end
        if (m_state != game_pkg::GS_KEEPER) begin
            round_done_gk = 1'b1;
            is_scored_gk  = 1'b1;
        end
        @(negedge clk);
        round_done_sh = 1'b0;
        is_scored_sh  = 1'b0;
        round_done_gk = 1'b0;
        is_scored_gk  = 1'b0;
        repeat (4) begin
            check_outputs();
            if (tx_busy !== 1'b0) begin
                fails++;
                $display("a frame was sent for an ignored strobe");
            end
            @(negedge clk);
        end
    endtask

    task automatic play_match();
        int n;
        n = 0;
        start_match();
        while (!m_end && n < 64) begin
            try_wrong_role();
            send_round(($urandom % 4) != 0);
            wait_busy(1'b1, 8);
            wait_busy(1'b0, 12 * link_pkg::CLKS_PER_BIT);
            wait_drained();
            n++;
        end
        if (!m_end) begin
            fails++;
            $display("match did not finish within %0d rounds", n);
        end
        try_wrong_role();  // nothing counts once decided
    endtask

    task automatic overflow_burst();
        int base;
        int n;
        start_match();
        check_value("link_overflow", 8'(link_overflow), 8'h00);
        base = rcv_total;
        repeat (8) send_round($urandom % 2);
        n = 0;
        while (link_overflow !== 1'b1 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (link_overflow !== 1'b1) begin
            fails++;
            $display("link_overflow did not rise after a burst of 8 frames");
        end
        wait_busy(1'b1, 8);
        wait_busy(1'b0, 12 * 8 * link_pkg::CLKS_PER_BIT);
        repeat (4) @(negedge clk);
        if (rcv_total - base < link_pkg::FRAME_DEPTH || rcv_total - base > 8) begin
            fails++;
            $display("burst delivered %0d frames, outside the allowed range", rcv_total - base);
        end
        exp_q.delete();  // dropped frames never arrive
    endtask

    // 8N1 receiver sampling near mid-bit
    initial begin : serial_rx
        logic [7:0] data;
        forever begin
            @(negedge clk);
            if (rst === 1'b0 && tx === 1'b0) begin
                repeat (link_pkg::CLKS_PER_BIT / 2 - 1) @(negedge clk);
                if (tx !== 1'b0) begin
                    fails++;
                    $display("start bit on tx shorter than half a bit");
                end
                for (int b = 0; b < 8; b++) begin
                    repeat (link_pkg::CLKS_PER_BIT) @(negedge clk);
                    data[b] = tx;  // lsb first
                end
                repeat (link_pkg::CLKS_PER_BIT) @(negedge clk);
                if (tx !== 1'b1) begin
                    fails++;
                    $display("stop bit missing on tx");
                end
                rcv_q.push_back(data);
                rcv_total++;
            end
        end
    end

    initial begin : compare_frames
        logic [7:0] exp_b;
        logic [7:0] got_b;
        forever begin
            @(negedge clk);
            while (exp_q.size() > 0 && rcv_q.size() > 0) begin
                exp_b = exp_q.pop_front();
                got_b = rcv_q.pop_front();
                if (got_b !== exp_b) begin
                    errors++;
                    $display("mismatch tx frame: got %h expected %h", got_b, exp_b);
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h82de));
        rst           = 1'b1;
        start         = 1'b0;
        round_done_gk = 1'b0;
        is_scored_gk  = 1'b0;
        round_done_sh = 1'b0;
        is_scored_sh  = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        m_player = '0;
        m_enemy  = '0;
        m_state  = game_pkg::GS_IDLE;
        m_end    = 1'b0;
        m_result = 1'b0;
        check_outputs();
        check_value("link_overflow", 8'(link_overflow), 8'h00);
        check_value("tx_busy", 8'(tx_busy), 8'h00);
        check_value("tx", 8'(tx), 8'h01);

        play_match();
        play_match();  // restart from GS_OVER
        overflow_burst();

        repeat (4) @(negedge clk);
        if (rcv_q.size() != 0) begin
            fails++;
            $display("%0d bytes received with no matching expected frame", rcv_q.size());
        end

        $display("done: %0d mismatches, %0d other errors, %0d frames received",
                 errors, fails, rcv_total);
        if (errors == 0 && fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== score_link.f ====
design/game_pkg.sv
design/link_pkg.sv
design/score_frame_if.sv
design/score_control.sv
design/frame_fifo.sv
design/frame_uart_tx.sv
design/score_link_top.sv
bench/score_link_tb.sv

// ==== Bender.yml ====
package:
  name: score_link

sources:
  - design/game_pkg.sv
  - design/link_pkg.sv
  - design/score_frame_if.sv
  - design/score_control.sv
  - design/frame_fifo.sv
  - design/frame_uart_tx.sv
  - design/score_link_top.sv
  - target: test
    files:
      - bench/score_link_tb.sv
